// File: Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing --timescale 1ns/1ps --top-module tb_image_capture -f project.f
	./obj_dir/Vtb_image_capture | tee /dev/stderr | grep -q "TESTS PASSED"

clean:
	rm -rf obj_dir

// File: logic/burst_writer.sv
// drains the word FIFO into memory one request/ack per word and reports frame completion
`timescale 1ns/1ps

module burst_writer (
  input  logic                 clk,
  input  logic                 mem_reset,
  input  mem_pkg::mem_addr_t   start_addr,
  input  logic                 frame_active,
  input  logic                 packer_empty,
  input  mem_pkg::mem_word_t   pop_word,
  input  logic                 pop_valid,
  output logic                 pop_ready,
  output logic                 writer_idle,
  output logic                 mem_wr_req,
  output mem_pkg::mem_wr_cmd_t mem_wr_cmd,
  input  logic                 mem_wr_ack,
  output logic                 frame_written
);
  import mem_pkg::*;

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_REQ,       // look for a word or the end of frame
    ST_WAIT_ACK   // request out, hold until ack
  } wr_state_t;

  wr_state_t state;
  logic      active_q;     // frame_active last cycle
  logic      frame_start;
  logic      drained;
  mem_addr_t wr_addr;      // address of next word

  assign frame_start = frame_active && !active_q;
  assign drained     = !frame_active && !pop_valid && packer_empty;
  assign writer_idle = (state == ST_IDLE);
  assign pop_ready   = (state == ST_WAIT_ACK) && mem_wr_ack;  // word retired on ack

  // -----------------------------------------------
  // write fsm
  // -----------------------------------------------
  always_ff @(posedge clk or posedge mem_reset) begin
    if (mem_reset) begin
      state         <= ST_IDLE;
      active_q      <= 1'b0;
      mem_wr_req    <= 1'b0;
      frame_written <= 1'b0;
    end else begin
      active_q      <= frame_active;
      frame_written <= 1'b0;

      case (state)
        ST_IDLE: begin
          if (frame_start) begin
            state <= ST_REQ;
          end
        end
        ST_REQ: begin
          if (pop_valid) begin
            mem_wr_req <= 1'b1;
            state      <= ST_WAIT_ACK;
          end else if (drained) begin
            frame_written <= 1'b1;  // last ack already seen
            state         <= ST_IDLE;
          end
        end
        ST_WAIT_ACK: begin
          if (mem_wr_ack) begin
            mem_wr_req <= 1'b0;
            state      <= ST_REQ;
          end
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

  // address and command, held stable while req is up
  always_ff @(posedge clk) begin
    if ((state == ST_IDLE) && frame_start) begin
      wr_addr <= start_addr;
    end else if (pop_ready) begin
      wr_addr <= wr_addr + ADDR_STEP;
    end
    if ((state == ST_REQ) && pop_valid) begin
      mem_wr_cmd <= '{addr: wr_addr, data: pop_word};
    end
  end

endmodule

// File: logic/frame_capture.sv
// trigger/arm/wait/store control that gates the pixel stream into the packer and counts lines
`timescale 1ns/1ps

module frame_capture (
  input  logic                             clk,
  input  logic                             mem_reset,
  input  logic                             trigger,
  input  logic [video_pkg::LINE_CNT_W-1:0] height,
  input  video_pkg::video_beat_t           s_beat,
  input  logic                             s_valid,
  output logic                             s_ready,
  output video_pkg::video_beat_t           pix_beat,
  output logic                             pix_valid,
  input  logic                             pix_ready,
  input  logic                             writer_idle,
  output logic                             frame_active,
  output logic                             frame_done,
  output logic                             skipped
);
  import video_pkg::*;

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_WAIT,
    ST_STORE
  } cap_state_t;

  cap_state_t            state;
  logic                  armed;      // trigger seen, capture pending
  logic [LINE_CNT_W-1:0] line_cnt;   // lines done in this frame
  logic                  fwd;        // current beat belongs to the packer
  logic                  pix_fire;
  logic                  line_last;

  // -----------------------------------------------
  // stream steering
  // -----------------------------------------------
  // in wait only the sof beat goes through, it opens the frame
  assign fwd = (state == ST_STORE) || ((state == ST_WAIT) && s_beat.sof);

  assign s_ready   = fwd ? pix_ready : 1'b1;  // otherwise sink everything
  assign pix_valid = s_valid && fwd;
  assign pix_beat  = s_beat;
  assign pix_fire  = pix_valid && pix_ready;

  assign line_last = (line_cnt >= height - 1'b1);  // eol of this line ends frame

  // -----------------------------------------------
  // capture fsm
  // -----------------------------------------------
  always_ff @(posedge clk or posedge mem_reset) begin
    if (mem_reset) begin
      state        <= ST_IDLE;
      armed        <= 1'b0;
      line_cnt     <= '0;
      frame_active <= 1'b0;
      frame_done   <= 1'b0;
      skipped      <= 1'b0;
    end else begin
      frame_done <= 1'b0;  // single cycle pulses
      skipped    <= 1'b0;

      if (trigger) begin
        armed <= 1'b1;
      end

      case (state)
        ST_IDLE: begin
          // writer must have finished the previous frame
          if (armed && writer_idle) begin
            state    <= ST_WAIT;
            armed    <= trigger;  // trigger in this cycle arms the next one
            line_cnt <= '0;
          end
          // frame went by unarmed
          if (s_valid && s_beat.sof) begin
            skipped <= 1'b1;
          end
        end

        default: begin  // wait and store share the line logic
          if (pix_fire) begin
            state        <= ST_STORE;
            frame_active <= 1'b1;
            if (pix_beat.eol) begin
              if (line_last) begin
                state        <= ST_IDLE;
                frame_active <= 1'b0;
                frame_done   <= 1'b1;
              end else begin
                line_cnt <= line_cnt + 1'b1;
              end
            end
          end
        end
      endcase
    end
  end

endmodule

// File: logic/image_capture_top.sv
// frame grabber top, connects capture, packer, word FIFO and burst writer
`timescale 1ns/1ps

module image_capture_top (
  input  logic                             clk,
  input  logic                             mem_reset,
  input  logic                             trigger,
  input  logic [video_pkg::LINE_CNT_W-1:0] height,
  input  mem_pkg::mem_addr_t               start_addr,
  input  video_pkg::video_beat_t           s_beat,
  input  logic                             s_valid,
  output logic                             s_ready,
  output logic                             frame_done,
  output logic                             skipped,
  output logic                             mem_wr_req,
  output mem_pkg::mem_wr_cmd_t             mem_wr_cmd,
  input  logic                             mem_wr_ack,
  output logic                             frame_written
);
  import video_pkg::*;
  import mem_pkg::*;

  // gated stream into packer
  video_beat_t pix_beat;
  logic        pix_valid;
  logic        pix_ready;
  // packer to fifo
  mem_word_t   push_word;
  logic        push_valid;
  logic        push_ready;
  // fifo to writer
  mem_word_t   pop_word;
  logic        pop_valid;
  logic        pop_ready;
  // capture/writer handshake
  logic        frame_active;
  logic        writer_idle;
  logic        packer_empty;

  frame_capture u_capture (
    .clk          (clk),
    .mem_reset    (mem_reset),
    .trigger      (trigger),
    .height       (height),
    .s_beat       (s_beat),
    .s_valid      (s_valid),
    .s_ready      (s_ready),
    .pix_beat     (pix_beat),
    .pix_valid    (pix_valid),
    .pix_ready    (pix_ready),
    .writer_idle  (writer_idle),
    .frame_active (frame_active),
    .frame_done   (frame_done),
    .skipped      (skipped)
  );

  pixel_packer u_packer (
    .clk          (clk),
    .mem_reset    (mem_reset),
    .pix_beat     (pix_beat),
    .pix_valid    (pix_valid),
    .pix_ready    (pix_ready),
    .push_word    (push_word),
    .push_valid   (push_valid),
    .push_ready   (push_ready),
    .packer_empty (packer_empty)
  );

  word_fifo #(
    .DEPTH (FIFO_DEPTH)
  ) u_fifo (
    .clk        (clk),
    .mem_reset  (mem_reset),
    .push_word  (push_word),
    .push_valid (push_valid),
    .push_ready (push_ready),
    .pop_word   (pop_word),
    .pop_valid  (pop_valid),
    .pop_ready  (pop_ready)
  );

  burst_writer u_writer (
    .clk           (clk),
    .mem_reset     (mem_reset),
    .start_addr    (start_addr),
    .frame_active  (frame_active),
    .packer_empty  (packer_empty),
    .pop_word      (pop_word),
    .pop_valid     (pop_valid),
    .pop_ready     (pop_ready),
    .writer_idle   (writer_idle),
    .mem_wr_req    (mem_wr_req),
    .mem_wr_cmd    (mem_wr_cmd),
    .mem_wr_ack    (mem_wr_ack),
    .frame_written (frame_written)
  );

endmodule

// File: logic/mem_pkg.sv
// memory port widths, write command layout and buffer depth, imported by the memory side blocks
package mem_pkg;

  // -----------------------------------------------
  // memory port
  // -----------------------------------------------
  localparam int MEM_ADDR_W = 29;   // word address
  localparam int MEM_DATA_W = 128;  // four packed pixels

  typedef logic [MEM_DATA_W-1:0] mem_word_t;
  typedef logic [MEM_ADDR_W-1:0] mem_addr_t;

  // word address moves by one burst of 8 per written word
  localparam mem_addr_t ADDR_STEP = 8;

  typedef struct packed {
    mem_addr_t addr;  // upper bits
    mem_word_t data;
  } mem_wr_cmd_t;

  // -----------------------------------------------
  // buffering
  // -----------------------------------------------
  localparam int FIFO_DEPTH = 16;  // words between packer and writer

endpackage

// File: logic/pixel_packer.sv
// packs four accepted pixels with fill bytes into one memory word for the word FIFO
`timescale 1ns/1ps

module pixel_packer (
  input  logic                   clk,
  input  logic                   mem_reset,
  input  video_pkg::video_beat_t pix_beat,
  input  logic                   pix_valid,
  output logic                   pix_ready,
  output mem_pkg::mem_word_t     push_word,
  output logic                   push_valid,
  input  logic                   push_ready,
  output logic                   packer_empty
);
  import video_pkg::*;
  import mem_pkg::*;

  logic [SLOT_W-1:0] slot;       // next slot to fill
  logic [SLOT_W-1:0] slot_idx;   // slot taken by the current pixel
  word_slot_t        new_slot;
  mem_word_t         acc;        // shift reg, oldest pixel on top
  mem_word_t         next_acc;
  mem_word_t         out_word;   // completed word
  logic              out_valid;
  logic              pix_fire;
  logic              word_done;  // fourth pixel accepted

  assign pix_ready = !out_valid || push_ready;  // room once output drains
  assign pix_fire  = pix_valid && pix_ready;
  assign slot_idx  = pix_beat.sof ? '0 : slot;  // sof restarts the group
  assign word_done = pix_fire && (slot_idx == SLOT_W'(PIXELS_PER_WORD - 1));

  assign new_slot = '{pixel: pix_beat.pixel, fill: FILL_BYTE};
  assign next_acc = {acc[MEM_DATA_W-SLOT_BITS-1:0], new_slot};

  // slot count and output register state
  always_ff @(posedge clk or posedge mem_reset) begin
    if (mem_reset) begin
      slot      <= '0;
      out_valid <= 1'b0;
    end else begin
      if (pix_fire) begin
        slot <= slot_idx + SLOT_W'(1);  // wraps after slot 3
      end
      if (word_done) begin
        out_valid <= 1'b1;
      end else if (push_ready) begin
        out_valid <= 1'b0;
      end
    end
  end

  // pixel data
  always_ff @(posedge clk) begin
    if (pix_fire) begin
      acc <= next_acc;
    end
    if (word_done) begin
      out_word <= next_acc;
    end
  end

  assign push_word    = out_word;
  assign push_valid   = out_valid;
  assign packer_empty = (slot == '0) && !out_valid;  // nothing partial or pending

endmodule

// File: logic/video_pkg.sv
// pixel stream types and word packing constants, imported by the capture and packer blocks
package video_pkg;

  // -----------------------------------------------
  // pixel stream
  // -----------------------------------------------
  localparam int LINE_CNT_W = 16;  // line counter and height width

  typedef struct packed {
    logic [7:0] red;    // top byte
    logic [7:0] green;
    logic [7:0] blue;
  } pixel_t;

  typedef struct packed {
    pixel_t pixel;
    logic   sof;        // first pixel of frame
    logic   eol;        // last pixel of line
  } video_beat_t;

  // -----------------------------------------------
  // packing into memory words
  // -----------------------------------------------
  localparam int PIXELS_PER_WORD = 4;
  localparam int SLOT_W          = $clog2(PIXELS_PER_WORD);  // slot counter width
  localparam logic [7:0] FILL_BYTE = 8'hff;                   // sits under each pixel

  // one pixel slot of a memory word
  typedef struct packed {
    pixel_t     pixel;
    logic [7:0] fill;
  } word_slot_t;

  localparam int SLOT_BITS = $bits(word_slot_t);  // 32

endpackage

// File: logic/word_fifo.sv
// single clock FIFO of memory words, packer writes and the burst writer reads
`timescale 1ns/1ps

module word_fifo #(
  parameter int DEPTH = mem_pkg::FIFO_DEPTH  // power of two
) (
  input  logic               clk,
  input  logic               mem_reset,
  input  mem_pkg::mem_word_t push_word,
  input  logic               push_valid,
  output logic               push_ready,
  output mem_pkg::mem_word_t pop_word,
  output logic               pop_valid,
  input  logic               pop_ready
);
  import mem_pkg::*;

  localparam int          AW       = $clog2(DEPTH);
  localparam logic [AW:0] FULL_CNT = (AW + 1)'(DEPTH);

  mem_word_t     ram [DEPTH];
  logic [AW-1:0] wr_ptr;
  logic [AW-1:0] rd_ptr;
  logic [AW:0]   count;      // one extra bit for full
  logic          push_fire;
  logic          pop_fire;

  assign push_ready = (count != FULL_CNT);
  assign pop_valid  = (count != '0);
  assign pop_word   = ram[rd_ptr];  // head of queue
  assign push_fire  = push_valid && push_ready;
  assign pop_fire   = pop_valid && pop_ready;

  // -----------------------------------------------
  // pointers and occupancy
  // -----------------------------------------------
  always_ff @(posedge clk or posedge mem_reset) begin
    if (mem_reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push_fire) begin
        wr_ptr <= wr_ptr + 1'b1;  // wraps, depth is 2^n
      end
      if (pop_fire) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({push_fire, pop_fire})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;  // none or both
      endcase
    end
  end

  // storage
  always_ff @(posedge clk) begin
    if (push_fire) begin
      ram[wr_ptr] <= push_word;
    end
  end

endmodule

// File: project.f
+incdir+tb
logic/video_pkg.sv
logic/mem_pkg.sv
logic/frame_capture.sv
logic/pixel_packer.sv
logic/word_fifo.sv
logic/burst_writer.sv
logic/image_capture_top.sv
tb/tb_image_capture.sv

// File: tb/tb_checks.svh
// typed compare tasks, failure stop and the xorshift generator, included in the testbench module
`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

// --------------------------------------------------
// failure stop
// --------------------------------------------------
task automatic stop_run();
  $display("TESTS FAILED");
  $fatal(1, "simulation stopped at the first failure");
endtask

// wrong value, with sim time
task automatic report_mismatch(input string msg);
  $display("[ERROR] %0t: %s", $time, msg);
  stop_run();
endtask

// timeouts and stray bus activity
task automatic report_fault(input string msg);
  $display("%s, at time %0t", msg, $time);
  stop_run();
endtask

// --------------------------------------------------
// compares, one per kind of result
// --------------------------------------------------
task automatic check_cmd(input string what, input mem_pkg::mem_wr_cmd_t got,
                         input mem_pkg::mem_wr_cmd_t exp);
  if (got !== exp) begin
    report_mismatch($sformatf("%s: addr %h data %h, expected addr %h data %h",
                              what, got.addr, got.data, exp.addr, exp.data));
  end
endtask

task automatic check_count(input string what, input int got, input int exp);
  if (got != exp) begin
    report_mismatch($sformatf("%s: got %0d, expected %0d", what, got, exp));
  end
endtask

task automatic check_bit(input string what, input logic got, input logic exp);
  if (got !== exp) begin
    report_mismatch($sformatf("%s: got %b, expected %b", what, got, exp));
  end
endtask

// xorshift32 step, shifts 13/17/5
function automatic logic [31:0] xorshift32(input logic [31:0] x);
  logic [31:0] y;
  y = x ^ (x << 13);
  y = y ^ (y >> 17);
  y = y ^ (y << 5);
  return y;
endfunction

`endif

// File: tb/tb_image_capture.sv
// testbench for the frame grabber that sends RGB frames and checks each memory write against a model
`timescale 1ns/1ps

module tb_image_capture;
  import video_pkg::*;
  import mem_pkg::*;

  localparam int          WIDTH   = 8;     // pixels per line
  localparam int          LINES   = 4;
  localparam int          NPIX    = WIDTH * LINES;
  localparam int          JUNK    = 5;     // more than one word of non-sof beats
  localparam int          TIMEOUT = 2000;  // cycles per wait loop
  localparam logic [31:0] SEED    = 32'h6328_fdfa;

  logic                  clk;
  logic                  mem_reset;
  logic                  trigger;
  logic [LINE_CNT_W-1:0] height;
  mem_addr_t             start_addr;
  video_beat_t           s_beat;
  logic                  s_valid;
  logic                  s_ready;
  logic                  frame_done;
  logic                  skipped;
  logic                  mem_wr_req;
  mem_wr_cmd_t           mem_wr_cmd;
  logic                  mem_wr_ack;
  logic                  frame_written;

  // --------------------------------------------------
  // model state
  // --------------------------------------------------
  pixel_t      frame_pix [NPIX];   // frame on the wire
  pixel_t      exp_pix [$];        // expected in memory in pixel order
  mem_addr_t   exp_base;
  int          write_base;         // write_cnt when the frame started
  logic        ack_random;         // low holds ack high
  logic [31:0] stim_rng;
  logic [31:0] ack_rng;
  int          write_cnt;          // counted by the compare process
  int          done_cnt;
  int          written_cnt;
  int          skip_cnt;
  int          done_at_written;    // snapshots at frame_written
  int          writes_at_written;

  `include "tb_checks.svh"

  image_capture_top dut (.*);

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // word idx of the frame with four pixels from the top down and a fill byte under each
  function automatic mem_wr_cmd_t ref_cmd(input mem_addr_t base, input int idx);
    mem_wr_cmd_t cmd;
    int          k;
    cmd.addr = base + mem_addr_t'(8 * idx);  // 8 per word
    cmd.data = '0;
    for (k = 0; k < 4; k++) begin
      cmd.data[127 - 32 * k -: 24] = exp_pix[4 * idx + k];
      cmd.data[103 - 32 * k -: 8]  = 8'hff;
    end
    return cmd;
  endfunction

  // memory responder holds ack high or acks at random while req is up
  initial begin
    mem_wr_ack = 1'b0;
    ack_rng    = SEED;
    forever begin
      @(negedge clk);
      ack_rng    = xorshift32(ack_rng);
      mem_wr_ack = !ack_random || (mem_wr_req && ack_rng[2:0] == 3'd0);  // ~1 in 8
    end
  end

  // --------------------------------------------------
  // compare process on the rising edge
  // --------------------------------------------------
  always @(posedge clk) begin
    if (mem_wr_req && mem_wr_ack) begin
      if (write_cnt - write_base >= exp_pix.size() / 4) begin
        report_fault("memory write seen where no write was expected");
      end else begin
        check_cmd("memory write", mem_wr_cmd, ref_cmd(exp_base, write_cnt - write_base));
      end
      write_cnt++;
    end
    done_cnt += int'(frame_done);
    skip_cnt += int'(skipped);
    if (frame_written) begin
      written_cnt++;
      done_at_written   = done_cnt;
      writes_at_written = write_cnt;
    end
  end

  // --------------------------------------------------
  // stimulus on the falling edge
  // --------------------------------------------------
  task automatic send_beat(input video_beat_t beat, input logic gaps);
    int waited;
    waited = 0;
    if (gaps) begin
      stim_rng = xorshift32(stim_rng);
      repeat (stim_rng[1:0]) @(negedge clk);  // 0..3 idle cycles with valid low
    end
    s_beat  = beat;
    s_valid = 1'b1;
    @(posedge clk);
    while (!s_ready) begin
      waited++;
      if (waited > TIMEOUT) begin
        report_fault("timed out waiting for s_ready");
      end
      @(posedge clk);
    end
    @(negedge clk);
    s_valid = 1'b0;
  endtask

  task automatic fill_frame();
    int i;
    for (i = 0; i < NPIX; i++) begin
      stim_rng     = xorshift32(stim_rng);
      frame_pix[i] = pixel_t'(stim_rng[23:0]);
    end
  endtask

  // JUNK non-sof beats first when junk is set
  task automatic send_frame(input logic gaps, input logic junk);
    video_beat_t beat;
    int          i;
    for (i = (junk ? -JUNK : 0); i < NPIX; i++) begin
      stim_rng   = xorshift32(stim_rng);
      beat.pixel = (i < 0) ? pixel_t'(stim_rng[23:0]) : frame_pix[i];
      beat.sof   = (i == 0);
      beat.eol   = (i >= 0) && (i % WIDTH == WIDTH - 1);
      send_beat(beat, gaps);
    end
  endtask

  // trigger a capture and send the frame, then wait for frame_written and check counts
  task automatic capture_frame(input mem_addr_t base, input logic gaps, input logic junk);
    int done_base;
    int written_base;
    int waited;
    done_base    = done_cnt;
    written_base = written_cnt;
    waited       = 0;
    exp_pix.delete();
    foreach (frame_pix[i]) begin
      exp_pix.push_back(frame_pix[i]);
    end
    exp_base   = base;
    write_base = write_cnt;
    start_addr = base;
    trigger    = 1'b1;
    @(negedge clk);
    trigger = 1'b0;
    repeat (2) @(negedge clk);  // armed and then waiting for sof
    send_frame(gaps, junk);
    while (written_cnt == written_base) begin
      waited++;
      if (waited > TIMEOUT) begin
        report_fault("timed out waiting for frame_written");
      end
      @(negedge clk);
    end
    check_count("words written", writes_at_written - write_base, NPIX / 4);
    check_count("frame_done ahead of frame_written", done_at_written - done_base, 1);
    check_bit("frame_written after its pulse", frame_written, 1'b0);  // one cycle wide
  endtask

  // --------------------------------------------------
  // test sequence
  // --------------------------------------------------
  initial begin
    int skip_base;
    mem_reset  = 1'b1;
    trigger    = 1'b0;
    height     = LINE_CNT_W'(LINES);
    start_addr = '0;
    s_beat     = '0;
    s_valid    = 1'b0;
    ack_random = 1'b0;
    stim_rng   = SEED;
    exp_base   = '0;
    write_base = 0;
    repeat (16) @(negedge clk);
    mem_reset = 1'b0;
    @(negedge clk);

    check_bit("mem_wr_req after reset", mem_wr_req, 1'b0);
    check_bit("frame_done after reset", frame_done, 1'b0);
    check_bit("frame_written after reset", frame_written, 1'b0);
    check_bit("skipped after reset", skipped, 1'b0);
    check_bit("s_ready after reset", s_ready, 1'b1);

    fill_frame();
    capture_frame(29'h0100_0000, 1'b0, 1'b0);  // ack always high
    ack_random = 1'b1;
    capture_frame(29'h0100_0000, 1'b1, 1'b0);  // same pixels with stalls on both sides

    // unarmed frame goes by
    skip_base  = skip_cnt;
    exp_pix.delete();
    write_base = write_cnt;
    fill_frame();
    send_frame(1'b0, 1'b0);
    repeat (20) @(negedge clk);  // window for stray writes
    check_count("skipped pulses", skip_cnt - skip_base, 1);
    check_count("writes of a skipped frame", write_cnt - write_base, 0);

    // junk ahead of sof and a second trigger at a new address
    capture_frame(29'h0000_2000, 1'b1, 1'b1);
    fill_frame();
    capture_frame(29'h1abc_0040, 1'b0, 1'b1);

    $display("TESTS PASSED");
    $finish;
  end

endmodule
